//--- Bender.yml
package:
  name: cpu_control

sources:
  - src/cpu_ctrl_pkg.sv
  - src/instr_decode.sv
  - src/step_override.sv
  - src/cpu_control.sv
  - target: test
    files:
      - sim/tb_cpu_control.sv

//--- sim/tb_cpu_control.sv
`timescale 1ns/10ps

module tb_cpu_control;

    localparam int MAX_CYCLES = 4000;   // Tests need about 2900

    logic       clk;
    logic       reset;
    logic [7:0] opcode_early;
    logic [2:0] m_cycle;

    logic [1:0] alu_src_a, alu_op_prefix, alu_op_src, alu_dst, pc_src;
    logic [1:0] bus_op, db_src, ab_src, ct_op, rf_rdw_sel;
    logic [2:0] alu_src_b, rf_wr_sel, rf_rd_sel;
    logic       pc_we, flags_we, high_mask, next, stop, halt;

    logic [7:0]  model_op;   // Opcode latched at the last edge
    logic [31:0] rnd;
    int          cycles;
    int          i, c, p, k;

    cpu_control uut (
        .clk (clk), .reset (reset), .opcode_early (opcode_early), .m_cycle (m_cycle),
        .alu_src_a (alu_src_a), .alu_src_b (alu_src_b), .alu_op_prefix (alu_op_prefix),
        .alu_op_src (alu_op_src), .alu_dst (alu_dst), .pc_src (pc_src), .pc_we (pc_we),
        .rf_wr_sel (rf_wr_sel), .rf_rd_sel (rf_rd_sel), .rf_rdw_sel (rf_rdw_sel),
        .bus_op (bus_op), .db_src (db_src), .ab_src (ab_src), .ct_op (ct_op),
        .flags_we (flags_we), .high_mask (high_mask), .next (next), .stop (stop),
        .halt (halt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    ////////////////////
    // Reference model
    ////////////////////
    function automatic logic [34:0] expected_ctrl(input logic [7:0] op, input logic [2:0] mc);
        logic [1:0] src_a, op_pre, op_src, dst, pcs, rdw, bus, db, ab, ct;
        logic [2:0] src_b, wr, rd;
        logic       we_pc, we_fl, nxt, stp, hlt;
        logic       ld_r, alu, incdec8, ld16, incdec16, jp, st;
        logic [2:0] d, s;
        d = op[5:3];
        s = op[2:0];
        ld_r     = op[7:6] == 2'b01 && d != 3'd6 && s != 3'd6;
        alu      = op[7:6] == 2'b10 && s != 3'd6;
        incdec8  = op[7:6] == 2'b00 && op[2:1] == 2'b10 && d != 3'd6;
        ld16     = op[7:6] == 2'b00 && op[3:0] == 4'b0001;
        incdec16 = op[7:6] == 2'b00 && s == 3'b011;
        jp       = op == 8'hC3;
        st       = op == 8'h02 || op == 8'h12;
        // End word first
        {src_a, op_pre, op_src, dst, pcs, db, ab} = '0;
        {src_b, wr, rd, we_pc, we_fl, nxt, stp, hlt} = '0;
        bus = 2'd1;
        ct  = 2'd1;
        rdw = 2'd2;
        if (mc == 3'd0 || (mc == 3'd1 && (ld16 || jp))) begin
            if (op == 8'h00) begin
                nxt = 1'b0;
            end else if (op == 8'h76) begin
                hlt = 1'b1;
            end else if (op == 8'h10) begin
                stp = 1'b1;
            end else if (ld_r) begin
                {rd, wr, src_a, dst} = {s, d, 2'd1, 2'd1};
            end else if (alu) begin
                {rd, src_a, src_b, op_src, we_fl} = {s, 2'd0, 3'd2, 2'd1, 1'b1};
                dst = (d == 3'd7) ? 2'd3 : 2'd0;   // CP keeps A
            end else if (incdec8) begin
                {rd, wr, src_a, src_b, op_src, dst, we_fl} = {d, d, 2'd1, 3'd1, 2'd2, 2'd1, 1'b1};
            end else if (ld16 || jp) begin
                nxt = 1'b1;
            end else if (incdec16) begin
                {bus, ct, nxt} = {2'd0, 2'd0, 1'b1};
            end else if (st) begin
                {rdw, bus, ab, db, ct, nxt} = {op[5:4], 2'd2, 2'd2, 2'd1, 2'd0, 1'b1};
            end else begin
                {stp, hlt} = 2'b11;
            end
        end else if (mc == 3'd1 && incdec16) begin
            {src_b, rd, wr} = {3'd1, op[5:4], 1'b0, op[5:4], 1'b0};
        end else if (mc == 3'd2 && jp) begin
            {pcs, we_pc, bus, ct, nxt} = {2'd2, 1'b1, 2'd0, 2'd0, 1'b1};
        end else if (mc == 3'd2 && ld16) begin
            wr = {op[5:4], 1'b0};
        end else if (mc >= 3'd4) begin
            {stp, hlt, nxt} = 3'b111;
        end
        return {src_a, src_b, op_pre, op_src, dst, pcs, we_pc, wr, rd, rdw,
                bus, db, ab, ct, we_fl, 1'b0, nxt, stp, hlt};
    endfunction

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got %h, expected %h (opcode %h, m_cycle %0d)",
                     name, actual, expected, model_op, m_cycle);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic compare_outputs(input logic [34:0] e);
        check_value("alu_src_a", alu_src_a, e[34:33]);
        check_value("alu_src_b", alu_src_b, e[32:30]);
        check_value("alu_op_prefix", alu_op_prefix, e[29:28]);
        check_value("alu_op_src", alu_op_src, e[27:26]);
        check_value("alu_dst", alu_dst, e[25:24]);
        check_value("pc_src", pc_src, e[23:22]);
        check_value("pc_we", pc_we, e[21]);
        check_value("rf_wr_sel", rf_wr_sel, e[20:18]);
        check_value("rf_rd_sel", rf_rd_sel, e[17:15]);
        check_value("rf_rdw_sel", rf_rdw_sel, e[14:13]);
        check_value("bus_op", bus_op, e[12:11]);
        check_value("db_src", db_src, e[10:9]);
        check_value("ab_src", ab_src, e[8:7]);
        check_value("ct_op", ct_op, e[6:5]);
        check_value("flags_we", flags_we, e[4]);
        check_value("high_mask", high_mask, e[3]);
        check_value("next", next, e[2]);
        check_value("stop", stop, e[1]);
        check_value("halt", halt, e[0]);
    endtask

    // Samples 2 ns before each rising edge
    initial begin
        @(posedge clk);
        forever begin
            model_op = reset ? 8'h00 : opcode_early;
            #18;
            compare_outputs(expected_ctrl(model_op, m_cycle));
            @(posedge clk);
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles >= MAX_CYCLES) begin
                $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
                $display("** FAIL **");
                $fatal(1);
            end
        end
    end

    task automatic load_opcode(input logic [7:0] op);
        @(posedge clk);
        #2;
        opcode_early = op;
        m_cycle      = 3'd0;
    endtask

    // Drive a cycle index and wait until the outputs have settled
    task automatic step_cycle(input int mc);
        @(posedge clk);
        #2;
        m_cycle = mc[2:0];
        #15;
    endtask

    ////////////////////
    // Stimulus
    ////////////////////
    initial begin
        reset        = 1'b1;
        opcode_early = 8'hFF;   // Illegal opcode held through reset
        m_cycle      = 3'd0;
        rnd          = 32'd2;
        repeat (10) @(posedge clk);
        #2;
        reset        = 1'b0;
        opcode_early = 8'h00;
        #15;
        compare_outputs(expected_ctrl(8'h00, 3'd0));

        // Every opcode through every cycle index
        for (i = 0; i < 256; i++) begin
            load_opcode(i[7:0]);
            for (c = 0; c < 8; c++) begin
                step_cycle(c);
            end
        end

        for (p = 0; p < 3; p++) begin
            load_opcode({2'b00, p[1:0], 4'b0001});   // LD rr,nn
            step_cycle(0);
            check_value("next", next, 8'd1);
            step_cycle(1);
            check_value("next", next, 8'd1);
            step_cycle(2);
            check_value("rf_wr_sel", rf_wr_sel, {p[1:0], 1'b0});
            for (k = 0; k < 2; k++) begin
                load_opcode({2'b00, p[1:0], k[0], 3'b011});   // INC/DEC rr
                step_cycle(0);
                check_value("bus_op", bus_op, 8'd0);
                step_cycle(1);
                check_value("rf_rd_sel", rf_rd_sel, {p[1:0], 1'b0});
                check_value("rf_wr_sel", rf_wr_sel, {p[1:0], 1'b0});
                check_value("alu_src_b", alu_src_b, 8'd1);
            end
        end

        load_opcode(8'hC3);
        for (c = 0; c < 4; c++) begin
            step_cycle(c);
            check_value("pc_we", pc_we, (c == 2) ? 8'd1 : 8'd0);
            check_value("pc_src", pc_src, (c == 2) ? 8'd2 : 8'd0);
        end

        for (p = 0; p < 2; p++) begin
            load_opcode({3'b000, p[0], 4'b0010});   // LD (BC),A and LD (DE),A
            step_cycle(0);
            check_value("bus_op", bus_op, 8'd2);
            check_value("rf_rdw_sel", rf_rdw_sel, p[1:0]);
            check_value("ab_src", ab_src, 8'd2);
            check_value("db_src", db_src, 8'd1);
            step_cycle(1);
            check_value("bus_op", bus_op, 8'd1);
            check_value("next", next, 8'd0);
        end

        // New opcode every cycle
        repeat (500) begin
            rnd = lcg_next(rnd);
            @(posedge clk);
            #2;
            opcode_early = rnd[23:16];
            m_cycle      = {1'b0, rnd[9:8]};
        end

        // Reset in the middle of a JP
        load_opcode(8'hC3);
        step_cycle(0);
        step_cycle(1);
        @(posedge clk);
        #2;
        reset   = 1'b1;
        m_cycle = 3'd2;
        #15;
        check_value("pc_we", pc_we, 8'd1);
        @(posedge clk);
        #2;
        reset = 1'b0;
        #15;
        compare_outputs(expected_ctrl(8'h00, 3'd0));

        repeat (2) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- src/cpu_control.sv
`timescale 1ns/10ps

module cpu_control (
    input  logic                    clk,
    input  logic                    reset,
    input  cpu_ctrl_pkg::opcode_t   opcode_early,
    input  cpu_ctrl_pkg::mcycle_t   m_cycle,
    output cpu_ctrl_pkg::sel2_t     alu_src_a,
    output cpu_ctrl_pkg::alu_b_t    alu_src_b,
    output cpu_ctrl_pkg::sel2_t     alu_op_prefix,
    output cpu_ctrl_pkg::sel2_t     alu_op_src,
    output cpu_ctrl_pkg::sel2_t     alu_dst,
    output cpu_ctrl_pkg::sel2_t     pc_src,
    output logic                    pc_we,
    output cpu_ctrl_pkg::reg_sel_t  rf_wr_sel,
    output cpu_ctrl_pkg::reg_sel_t  rf_rd_sel,
    output cpu_ctrl_pkg::pair_sel_t rf_rdw_sel,
    output cpu_ctrl_pkg::sel2_t     bus_op,
    output cpu_ctrl_pkg::sel2_t     db_src,
    output cpu_ctrl_pkg::sel2_t     ab_src,
    output cpu_ctrl_pkg::sel2_t     ct_op,
    output logic                    flags_we,
    output logic                    high_mask,
    output logic                    next,
    output logic                    stop,
    output logic                    halt
);

    cpu_ctrl_pkg::opcode_t      opcode;
    cpu_ctrl_pkg::instr_class_t instr_class;
    cpu_ctrl_pkg::ctrl_word_t   base_word;

    instr_decode u_decode (
        .clk          (clk),
        .reset        (reset),
        .opcode_early (opcode_early),
        .opcode       (opcode),
        .instr_class  (instr_class),
        .base_word    (base_word)
    );

    // Later machine cycles
    step_override u_step (
        .clk           (clk),
        .reset         (reset),
        .opcode        (opcode),
        .instr_class   (instr_class),
        .base_word     (base_word),
        .m_cycle       (m_cycle),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .alu_op_prefix (alu_op_prefix),
        .alu_op_src    (alu_op_src),
        .alu_dst       (alu_dst),
        .pc_src        (pc_src),
        .pc_we         (pc_we),
        .rf_wr_sel     (rf_wr_sel),
        .rf_rd_sel     (rf_rd_sel),
        .rf_rdw_sel    (rf_rdw_sel),
        .bus_op        (bus_op),
        .db_src        (db_src),
        .ab_src        (ab_src),
        .ct_op         (ct_op),
        .flags_we      (flags_we),
        .high_mask     (high_mask),
        .next          (next),
        .stop          (stop),
        .halt          (halt)
    );

endmodule

//--- src/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    ////////////////////
    // Vector types
    ////////////////////
    typedef logic [7:0]  opcode_t;
    typedef logic [2:0]  mcycle_t;
    typedef logic [2:0]  reg_sel_t;      // B C D E H L - A
    typedef logic [1:0]  pair_sel_t;
    typedef logic [1:0]  sel2_t;
    typedef logic [2:0]  alu_b_t;
    typedef logic [3:0]  instr_class_t;
    typedef logic [31:0] ctrl_word_t;    // Everything but pc_src and high_mask

    // Instruction classes
    localparam instr_class_t CLS_NOP      = 4'd0;
    localparam instr_class_t CLS_LD_R     = 4'd1;
    localparam instr_class_t CLS_ALU      = 4'd2;
    localparam instr_class_t CLS_INCDEC8  = 4'd3;
    localparam instr_class_t CLS_LD16     = 4'd4;
    localparam instr_class_t CLS_INCDEC16 = 4'd5;
    localparam instr_class_t CLS_JP       = 4'd6;
    localparam instr_class_t CLS_ST_PAIR  = 4'd7;
    localparam instr_class_t CLS_HALT     = 4'd8;
    localparam instr_class_t CLS_STOP     = 4'd9;
    localparam instr_class_t CLS_ILLEGAL  = 4'd10;

    ////////////////////
    // Field codes
    ////////////////////
    localparam sel2_t BUS_IDLE  = 2'd0;
    localparam sel2_t BUS_FETCH = 2'd1;
    localparam sel2_t BUS_WRITE = 2'd2;
    localparam sel2_t BUS_READ  = 2'd3;

    localparam sel2_t AB_PC   = 2'd0;
    localparam sel2_t AB_PAIR = 2'd2;   // Address from rf_rdw_sel pair

    localparam sel2_t CT_HOLD = 2'd0;
    localparam sel2_t CT_INC  = 2'd1;

    localparam sel2_t DB_A = 2'd1;

    localparam sel2_t  SRC_A_ACC    = 2'd0;
    localparam sel2_t  SRC_A_REG    = 2'd1;
    localparam alu_b_t SRC_B_ONE    = 3'd1;
    localparam alu_b_t SRC_B_REG    = 3'd2;
    localparam sel2_t  OPSRC_FIELD  = 2'd1;   // Operation from opcode bits 5:3
    localparam sel2_t  OPSRC_INCDEC = 2'd2;
    localparam sel2_t  DST_ACC      = 2'd0;
    localparam sel2_t  DST_REG      = 2'd1;
    localparam sel2_t  DST_NONE     = 2'd3;   // CP only sets flags

    localparam sel2_t PC_FROM_TEMP = 2'd2;

    localparam pair_sel_t PAIR_BC = 2'd0;
    localparam pair_sel_t PAIR_DE = 2'd1;
    localparam pair_sel_t PAIR_HL = 2'd2;

    ////////////////////
    // Control word layout
    ////////////////////
    localparam int F_ALU_SRC_A     = 30;   // 2 bits
    localparam int F_ALU_SRC_B     = 27;   // 3 bits
    localparam int F_ALU_OP_PREFIX = 25;
    localparam int F_ALU_OP_SRC    = 23;
    localparam int F_ALU_DST       = 21;
    localparam int F_PC_WE         = 20;
    localparam int F_RF_WR_SEL     = 17;   // 3 bits
    localparam int F_RF_RD_SEL     = 14;   // 3 bits
    localparam int F_RF_RDW_SEL    = 12;
    localparam int F_BUS_OP        = 10;
    localparam int F_DB_SRC        = 8;
    localparam int F_AB_SRC        = 6;
    localparam int F_CT_OP         = 4;
    localparam int F_FLAGS_WE      = 3;
    localparam int F_NEXT          = 2;
    localparam int F_STOP          = 1;
    localparam int F_HALT          = 0;

    // Plain opcode fetch from PC with post increment
    localparam ctrl_word_t FETCH_WORD =
        (ctrl_word_t'(BUS_FETCH) << F_BUS_OP) |
        (ctrl_word_t'(AB_PC) << F_AB_SRC) |
        (ctrl_word_t'(CT_INC) << F_CT_OP) |
        (ctrl_word_t'(PAIR_HL) << F_RF_RDW_SEL);

endpackage

//--- src/instr_decode.sv
`timescale 1ns/10ps

module instr_decode (
    input  logic                       clk,
    input  logic                       reset,
    input  cpu_ctrl_pkg::opcode_t      opcode_early,
    output cpu_ctrl_pkg::opcode_t      opcode,
    output cpu_ctrl_pkg::instr_class_t instr_class,
    output cpu_ctrl_pkg::ctrl_word_t   base_word
);

    logic [1:0]                 quad;
    cpu_ctrl_pkg::reg_sel_t     dst;
    cpu_ctrl_pkg::reg_sel_t     src;
    cpu_ctrl_pkg::pair_sel_t    pair;
    cpu_ctrl_pkg::instr_class_t cls_d;
    cpu_ctrl_pkg::ctrl_word_t   word_d;

    assign quad = opcode_early[7:6];
    assign dst  = opcode_early[5:3];
    assign src  = opcode_early[2:0];
    assign pair = opcode_early[5:4];

    ////////////////////
    // Classification
    ////////////////////
    always_comb begin
        if (opcode_early == 8'h00) begin
            cls_d = cpu_ctrl_pkg::CLS_NOP;
        end else if (opcode_early == 8'h76) begin      // Sits in the LD r,r' block
            cls_d = cpu_ctrl_pkg::CLS_HALT;
        end else if (opcode_early == 8'h10) begin
            cls_d = cpu_ctrl_pkg::CLS_STOP;
        end else if (opcode_early == 8'hC3) begin
            cls_d = cpu_ctrl_pkg::CLS_JP;
        end else if (opcode_early == 8'h02 || opcode_early == 8'h12) begin
            cls_d = cpu_ctrl_pkg::CLS_ST_PAIR;
        end else if (quad == 2'b01 && dst != 3'd6 && src != 3'd6) begin
            cls_d = cpu_ctrl_pkg::CLS_LD_R;
        end else if (quad == 2'b10 && src != 3'd6) begin
            cls_d = cpu_ctrl_pkg::CLS_ALU;
        end else if (quad == 2'b00 && opcode_early[2:1] == 2'b10 && dst != 3'd6) begin
            cls_d = cpu_ctrl_pkg::CLS_INCDEC8;
        end else if (quad == 2'b00 && opcode_early[3:0] == 4'b0001) begin
            cls_d = cpu_ctrl_pkg::CLS_LD16;
        end else if (quad == 2'b00 && src == 3'b011) begin
            cls_d = cpu_ctrl_pkg::CLS_INCDEC16;
        end else begin
            // D3 DB DD E3 E4 EB EC ED F4 FC FD and all unsupported opcodes
            cls_d = cpu_ctrl_pkg::CLS_ILLEGAL;
        end
    end

    ////////////////////
    // First cycle word
    ////////////////////
    always_comb begin
        word_d = cpu_ctrl_pkg::FETCH_WORD;
        case (cls_d)
            cpu_ctrl_pkg::CLS_LD_R: begin
                word_d[cpu_ctrl_pkg::F_RF_RD_SEL +: 3] = src;
                word_d[cpu_ctrl_pkg::F_RF_WR_SEL +: 3] = dst;
                word_d[cpu_ctrl_pkg::F_ALU_SRC_A +: 2] = cpu_ctrl_pkg::SRC_A_REG;
                word_d[cpu_ctrl_pkg::F_ALU_DST +: 2]   = cpu_ctrl_pkg::DST_REG;
            end
            cpu_ctrl_pkg::CLS_ALU: begin
                word_d[cpu_ctrl_pkg::F_RF_RD_SEL +: 3]  = src;
                word_d[cpu_ctrl_pkg::F_ALU_SRC_A +: 2]  = cpu_ctrl_pkg::SRC_A_ACC;
                word_d[cpu_ctrl_pkg::F_ALU_SRC_B +: 3]  = cpu_ctrl_pkg::SRC_B_REG;
                word_d[cpu_ctrl_pkg::F_ALU_OP_SRC +: 2] = cpu_ctrl_pkg::OPSRC_FIELD;
                word_d[cpu_ctrl_pkg::F_FLAGS_WE]        = 1'b1;
                word_d[cpu_ctrl_pkg::F_ALU_DST +: 2]    = (dst == 3'd7) ?
                    cpu_ctrl_pkg::DST_NONE : cpu_ctrl_pkg::DST_ACC;
            end
            cpu_ctrl_pkg::CLS_INCDEC8: begin
                word_d[cpu_ctrl_pkg::F_RF_RD_SEL +: 3]  = dst;
                word_d[cpu_ctrl_pkg::F_RF_WR_SEL +: 3]  = dst;
                word_d[cpu_ctrl_pkg::F_ALU_SRC_A +: 2]  = cpu_ctrl_pkg::SRC_A_REG;
                word_d[cpu_ctrl_pkg::F_ALU_SRC_B +: 3]  = cpu_ctrl_pkg::SRC_B_ONE;
                word_d[cpu_ctrl_pkg::F_ALU_OP_SRC +: 2] = cpu_ctrl_pkg::OPSRC_INCDEC;
                word_d[cpu_ctrl_pkg::F_ALU_DST +: 2]    = cpu_ctrl_pkg::DST_REG;
                word_d[cpu_ctrl_pkg::F_FLAGS_WE]        = 1'b1;
            end
            cpu_ctrl_pkg::CLS_LD16, cpu_ctrl_pkg::CLS_JP: begin
                word_d[cpu_ctrl_pkg::F_NEXT] = 1'b1;   // Immediate bytes follow
            end
            cpu_ctrl_pkg::CLS_INCDEC16: begin
                word_d[cpu_ctrl_pkg::F_BUS_OP +: 2] = cpu_ctrl_pkg::BUS_IDLE;
                word_d[cpu_ctrl_pkg::F_CT_OP +: 2]  = cpu_ctrl_pkg::CT_HOLD;
                word_d[cpu_ctrl_pkg::F_NEXT]        = 1'b1;
            end
            cpu_ctrl_pkg::CLS_ST_PAIR: begin
                word_d[cpu_ctrl_pkg::F_RF_RDW_SEL +: 2] = pair;   // BC or DE
                word_d[cpu_ctrl_pkg::F_BUS_OP +: 2]     = cpu_ctrl_pkg::BUS_WRITE;
                word_d[cpu_ctrl_pkg::F_AB_SRC +: 2]     = cpu_ctrl_pkg::AB_PAIR;
                word_d[cpu_ctrl_pkg::F_DB_SRC +: 2]     = cpu_ctrl_pkg::DB_A;
                word_d[cpu_ctrl_pkg::F_CT_OP +: 2]      = cpu_ctrl_pkg::CT_HOLD;
                word_d[cpu_ctrl_pkg::F_NEXT]            = 1'b1;
            end
            cpu_ctrl_pkg::CLS_HALT: word_d[cpu_ctrl_pkg::F_HALT] = 1'b1;
            cpu_ctrl_pkg::CLS_STOP: word_d[cpu_ctrl_pkg::F_STOP] = 1'b1;
            cpu_ctrl_pkg::CLS_ILLEGAL: begin
                word_d[cpu_ctrl_pkg::F_STOP] = 1'b1;
                word_d[cpu_ctrl_pkg::F_HALT] = 1'b1;
            end
            default: word_d = cpu_ctrl_pkg::FETCH_WORD;   // NOP
        endcase
    end

    // Opcode arrives one cycle early
    always_ff @(posedge clk) begin
        if (reset) begin
            opcode      <= 8'h00;
            instr_class <= cpu_ctrl_pkg::CLS_NOP;
            base_word   <= cpu_ctrl_pkg::FETCH_WORD;
        end else begin
            opcode      <= opcode_early;
            instr_class <= cls_d;
            base_word   <= word_d;
        end
    end

    // NOP never stops or halts the core
    assert property (@(posedge clk) disable iff (reset)
        (instr_class == cpu_ctrl_pkg::CLS_NOP) |->
            !(base_word[cpu_ctrl_pkg::F_STOP] || base_word[cpu_ctrl_pkg::F_HALT]));

endmodule

//--- src/step_override.sv
`timescale 1ns/10ps

module step_override (
    input  logic                       clk,
    input  logic                       reset,
    input  cpu_ctrl_pkg::opcode_t      opcode,
    input  cpu_ctrl_pkg::instr_class_t instr_class,
    input  cpu_ctrl_pkg::ctrl_word_t   base_word,
    input  cpu_ctrl_pkg::mcycle_t      m_cycle,
    output cpu_ctrl_pkg::sel2_t        alu_src_a,
    output cpu_ctrl_pkg::alu_b_t       alu_src_b,
    output cpu_ctrl_pkg::sel2_t        alu_op_prefix,
    output cpu_ctrl_pkg::sel2_t        alu_op_src,
    output cpu_ctrl_pkg::sel2_t        alu_dst,
    output cpu_ctrl_pkg::sel2_t        pc_src,
    output logic                       pc_we,
    output cpu_ctrl_pkg::reg_sel_t     rf_wr_sel,
    output cpu_ctrl_pkg::reg_sel_t     rf_rd_sel,
    output cpu_ctrl_pkg::pair_sel_t    rf_rdw_sel,
    output cpu_ctrl_pkg::sel2_t        bus_op,
    output cpu_ctrl_pkg::sel2_t        db_src,
    output cpu_ctrl_pkg::sel2_t        ab_src,
    output cpu_ctrl_pkg::sel2_t        ct_op,
    output logic                       flags_we,
    output logic                       high_mask,
    output logic                       next,
    output logic                       stop,
    output logic                       halt
);

    cpu_ctrl_pkg::ctrl_word_t word;
    cpu_ctrl_pkg::sel2_t      pc_sel;
    cpu_ctrl_pkg::reg_sel_t   pair_reg;

    assign pair_reg = {opcode[5:4], 1'b0};   // High register of the pair

    ////////////////////
    // Cycle overrides
    ////////////////////
    always_comb begin
        word   = cpu_ctrl_pkg::FETCH_WORD;   // End word unless overridden
        pc_sel = 2'd0;
        case (m_cycle)
            3'd0: word = base_word;
            3'd1: begin
                case (instr_class)
                    cpu_ctrl_pkg::CLS_LD16, cpu_ctrl_pkg::CLS_JP: begin
                        word = base_word;
                        word[cpu_ctrl_pkg::F_NEXT] = 1'b1;
                    end
                    cpu_ctrl_pkg::CLS_INCDEC16: begin
                        word[cpu_ctrl_pkg::F_ALU_SRC_B +: 3] = cpu_ctrl_pkg::SRC_B_ONE;
                        word[cpu_ctrl_pkg::F_RF_RD_SEL +: 3] = pair_reg;
                        word[cpu_ctrl_pkg::F_RF_WR_SEL +: 3] = pair_reg;
                    end
                    default: word = cpu_ctrl_pkg::FETCH_WORD;
                endcase
            end
            3'd2: begin
                case (instr_class)
                    cpu_ctrl_pkg::CLS_JP: begin
                        pc_sel = cpu_ctrl_pkg::PC_FROM_TEMP;
                        word[cpu_ctrl_pkg::F_PC_WE]      = 1'b1;
                        word[cpu_ctrl_pkg::F_BUS_OP +: 2] = cpu_ctrl_pkg::BUS_IDLE;
                        word[cpu_ctrl_pkg::F_CT_OP +: 2]  = cpu_ctrl_pkg::CT_HOLD;
                        word[cpu_ctrl_pkg::F_NEXT]       = 1'b1;
                    end
                    cpu_ctrl_pkg::CLS_LD16: begin
                        word[cpu_ctrl_pkg::F_RF_WR_SEL +: 3] = pair_reg;
                    end
                    default: word = cpu_ctrl_pkg::FETCH_WORD;
                endcase
            end
            3'd3: word = cpu_ctrl_pkg::FETCH_WORD;
            default: begin
                // No instruction runs this long
                word[cpu_ctrl_pkg::F_STOP] = 1'b1;
                word[cpu_ctrl_pkg::F_HALT] = 1'b1;
                word[cpu_ctrl_pkg::F_NEXT] = 1'b1;
            end
        endcase
    end

    assign alu_src_a     = word[cpu_ctrl_pkg::F_ALU_SRC_A +: 2];
    assign alu_src_b     = word[cpu_ctrl_pkg::F_ALU_SRC_B +: 3];
    assign alu_op_prefix = word[cpu_ctrl_pkg::F_ALU_OP_PREFIX +: 2];
    assign alu_op_src    = word[cpu_ctrl_pkg::F_ALU_OP_SRC +: 2];
    assign alu_dst       = word[cpu_ctrl_pkg::F_ALU_DST +: 2];
    assign pc_src        = pc_sel;
    assign pc_we         = word[cpu_ctrl_pkg::F_PC_WE];
    assign rf_wr_sel     = word[cpu_ctrl_pkg::F_RF_WR_SEL +: 3];
    assign rf_rd_sel     = word[cpu_ctrl_pkg::F_RF_RD_SEL +: 3];
    assign rf_rdw_sel    = word[cpu_ctrl_pkg::F_RF_RDW_SEL +: 2];
    assign bus_op        = word[cpu_ctrl_pkg::F_BUS_OP +: 2];
    assign db_src        = word[cpu_ctrl_pkg::F_DB_SRC +: 2];
    assign ab_src        = word[cpu_ctrl_pkg::F_AB_SRC +: 2];
    assign ct_op         = word[cpu_ctrl_pkg::F_CT_OP +: 2];
    assign flags_we      = word[cpu_ctrl_pkg::F_FLAGS_WE];
    assign high_mask     = 1'b0;   // No high page accesses in this set
    assign next          = word[cpu_ctrl_pkg::F_NEXT];
    assign stop          = word[cpu_ctrl_pkg::F_STOP];
    assign halt          = word[cpu_ctrl_pkg::F_HALT];

    // PC load belongs to the JP target cycle only
    assert property (@(posedge clk) disable iff (reset) pc_we |-> (m_cycle == 3'd2));

    assert property (@(posedge clk) disable iff (reset) !(flags_we && stop));

endmodule

//--- verilog.f
src/cpu_ctrl_pkg.sv
src/instr_decode.sv
src/step_override.sv
src/cpu_control.sv
sim/tb_cpu_control.sv
